// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = evr_link_rx_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
source/link_ctrl_pkg.sv
source/sym_pkg.sv
source/sym_if.sv
source/rx_symbol_path.sv
source/align_counters.sv
source/link_reset_fsm.sv
source/evr_link_rx.sv
test/evr_link_rx_props.sv
test/evr_link_rx_tb.sv

// ==== source/align_counters.sv ====
// alignment counters: saturating comma count and CHECK timeout count

`timescale 1ns/1ps

module align_counters #(
    parameter int COMMAS_NEEDED = 60,
    parameter int CHECK_TIMEOUT = 125000
) (
    input  logic clk,
    input  logic rst,
    input  logic counting,      // controller in CHECK
    input  logic comma_seen,
    output logic commas_done,   // enough commas seen
    output logic timed_out      // CHECK lasted too long
);

    // widths sized to hold the limit itself
    localparam int COMMA_W   = $clog2(COMMAS_NEEDED + 1);
    localparam int TIMEOUT_W = $clog2(CHECK_TIMEOUT + 1);

    localparam logic [COMMA_W-1:0]   COMMA_LIM   = COMMA_W'(COMMAS_NEEDED);
    localparam logic [TIMEOUT_W-1:0] TIMEOUT_LIM = TIMEOUT_W'(CHECK_TIMEOUT);

    logic [COMMA_W-1:0]   comma_cnt;
    logic [TIMEOUT_W-1:0] timeout_cnt;

    // --------------------
    // counters
    // --------------------
    always_ff @(posedge clk) begin
        if (rst || !counting) begin
            comma_cnt   <= '0;      // fresh count on every CHECK entry
            timeout_cnt <= '0;
        end else begin
            // commas, holds at the limit
            if (comma_seen && (comma_cnt != COMMA_LIM)) begin
                comma_cnt <= comma_cnt + 1'b1;
            end
            // free running while in CHECK, holds at the limit
            if (timeout_cnt != TIMEOUT_LIM) begin
                timeout_cnt <= timeout_cnt + 1'b1;
            end
        end
    end

    // completion flags
    assign commas_done = (comma_cnt == COMMA_LIM);
    assign timed_out   = (timeout_cnt == TIMEOUT_LIM);

endmodule

// ==== source/evr_link_rx.sv ====
// top level of the rx link supervisor: ports, symbol bundle, three submodules

`timescale 1ns/1ps

module evr_link_rx #(
    parameter int COMMAS_NEEDED = link_ctrl_pkg::COMMAS_NEEDED_DEFAULT,
    parameter int CHECK_TIMEOUT = link_ctrl_pkg::CHECK_TIMEOUT_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  rst,
    // decoded symbols from the transceiver
    input  logic [sym_pkg::SYM_W-1:0]             rxdata,
    input  logic [sym_pkg::SYM_BYTES-1:0]         rxcharisk,
    input  logic [sym_pkg::SYM_BYTES-1:0]         rxdisperr,
    input  logic [sym_pkg::SYM_BYTES-1:0]         rxnotintable,
    input  logic                                  reset_done,
    input  logic                                  soft_reset,
    // gated data and link status
    output logic [sym_pkg::SYM_W-1:0]             rxdata_out,
    output logic [sym_pkg::SYM_BYTES-1:0]         rxcharisk_out,
    output logic                                  ready,
    output logic                                  gt_reset,
    output logic [link_ctrl_pkg::RESET_CNT_W-1:0] reset_cnt
);

    logic comma_seen;
    logic error_seen;
    logic counting;
    logic commas_done;
    logic timed_out;

    // --------------------
    // symbol bundle
    // --------------------
    sym_if sym_bus ();  // source side driven here

    assign sym_bus.data       = rxdata;
    assign sym_bus.charisk    = rxcharisk;
    assign sym_bus.disperr    = rxdisperr;
    assign sym_bus.notintable = rxnotintable;

    // --------------------
    // submodules
    // --------------------
    rx_symbol_path rx_symbol_path_i (
        .clk           (clk),
        .rst           (rst),
        .sym           (sym_bus.sink),
        .ready         (ready),
        .comma_seen    (comma_seen),
        .error_seen    (error_seen),
        .rxdata_out    (rxdata_out),
        .rxcharisk_out (rxcharisk_out)
    );

    align_counters #(
        .COMMAS_NEEDED (COMMAS_NEEDED),
        .CHECK_TIMEOUT (CHECK_TIMEOUT)
    ) align_counters_i (
        .clk         (clk),
        .rst         (rst),
        .counting    (counting),
        .comma_seen  (comma_seen),
        .commas_done (commas_done),
        .timed_out   (timed_out)
    );

    link_reset_fsm link_reset_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .error_seen  (error_seen),
        .reset_done  (reset_done),
        .commas_done (commas_done),
        .timed_out   (timed_out),
        .soft_reset  (soft_reset),
        .counting    (counting),
        .ready       (ready),
        .gt_reset    (gt_reset),
        .reset_cnt   (reset_cnt)
    );

endmodule

// ==== source/link_ctrl_pkg.sv ====
// link controller state enum, default alignment limits, reset counter width

package link_ctrl_pkg;

    // --------------------
    // controller states
    // --------------------
    // two-bit code with 2'd3 left unused
    typedef enum logic [1:0] {
        READY = 2'd0,   // aligned and passing data out
        RESET = 2'd1,   // transceiver reset issued until reset done
        CHECK = 2'd2    // counting commas under a timeout
    } link_state_t;

    // --------------------
    // alignment limits
    // --------------------
    // commas seen in CHECK before the link counts as aligned
    localparam int COMMAS_NEEDED_DEFAULT = 60;

    // cycles allowed in CHECK (about 1 ms at 125 MHz)
    localparam int CHECK_TIMEOUT_DEFAULT = 125000;

    // --------------------
    // status
    // --------------------
    localparam int RESET_CNT_W = 32;    // width of the wrapping reset pulse counter

endpackage

// ==== source/link_reset_fsm.sv ====
// link controller FSM, transceiver reset pulse, ready level and reset counter

`timescale 1ns/1ps

module link_reset_fsm (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  error_seen,
    input  logic                                  reset_done,   // transceiver start-up done
    input  logic                                  commas_done,
    input  logic                                  timed_out,
    input  logic                                  soft_reset,   // external, not counted
    output logic                                  counting,     // high in CHECK only
    output logic                                  ready,
    output logic                                  gt_reset,
    output logic [link_ctrl_pkg::RESET_CNT_W-1:0] reset_cnt
);

    link_ctrl_pkg::link_state_t state;
    link_ctrl_pkg::link_state_t next_state;

    logic reset_lvl;    // registered state == RESET
    logic reset_dly;    // reset_lvl one cycle later
    logic reset_pulse;  // one cycle strobe on rising reset_lvl

    // --------------------
    // state register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= link_ctrl_pkg::CHECK;  // start by looking for commas
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            link_ctrl_pkg::READY: begin
                if (error_seen) next_state = link_ctrl_pkg::RESET;  // lost the link
            end
            link_ctrl_pkg::RESET: begin
                if (reset_done) next_state = link_ctrl_pkg::CHECK;
            end
            link_ctrl_pkg::CHECK: begin
                // alignment wins over a timeout in the same cycle
                if (commas_done && reset_done) begin
                    next_state = link_ctrl_pkg::READY;
                end else if (timed_out) begin
                    next_state = link_ctrl_pkg::RESET;
                end
            end
            default: next_state = link_ctrl_pkg::RESET;  // unused code
        endcase
    end

    assign counting = (state == link_ctrl_pkg::CHECK);

    // --------------------
    // outputs
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ready       <= 1'b0;
            reset_lvl   <= 1'b0;
            reset_dly   <= 1'b0;
            reset_pulse <= 1'b0;
            reset_cnt   <= '0;
        end else begin
            ready       <= (state == link_ctrl_pkg::READY);
            reset_lvl   <= (state == link_ctrl_pkg::RESET);
            reset_dly   <= reset_lvl;
            reset_pulse <= reset_lvl & ~reset_dly;  // rising edge, 2 cycles after entry
            if (reset_pulse) begin
                reset_cnt <= reset_cnt + 1'b1;      // wraps
            end
        end
    end

    // soft reset goes straight through
    assign gt_reset = reset_pulse | soft_reset;

endmodule

// ==== source/rx_symbol_path.sv ====
// rx symbol path: comma and code error detection, data gating by alignment

`timescale 1ns/1ps

module rx_symbol_path (
    input  logic                          clk,
    input  logic                          rst,
    sym_if.sink                           sym,
    input  logic                          ready,          // link aligned
    output logic                          comma_seen,     // low byte K28.5, registered
    output logic                          error_seen,     // any code error, registered
    output logic [sym_pkg::SYM_W-1:0]     rxdata_out,
    output logic [sym_pkg::SYM_BYTES-1:0] rxcharisk_out
);

    logic comma_now;    // this cycle's word
    logic error_now;

    // --------------------
    // detection
    // --------------------
    // only the low byte counts, high byte commas belong to the data protocol
    assign comma_now = sym.charisk[0] &&
                       (sym.data[sym_pkg::BYTE_W-1:0] == sym_pkg::COMMA_K28_5);

    // disparity or table error in either byte
    assign error_now = (|sym.disperr) || (|sym.notintable);

    always_ff @(posedge clk) begin
        if (rst) begin
            comma_seen <= 1'b0;
            error_seen <= 1'b0;
        end else begin
            comma_seen <= comma_now;
            error_seen <= error_now;
        end
    end

    // --------------------
    // output data
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rxdata_out    <= '0;
            rxcharisk_out <= '0;
        end else begin
            rxdata_out    <= ready ? sym.data : '0;  // event codes only when aligned
            rxcharisk_out <= sym.charisk;           // same delay, never gated
        end
    end

endmodule

// ==== source/sym_if.sv ====
// interface for one cycle of decoded rx symbols, source and sink modports

`timescale 1ns/1ps

interface sym_if;

    logic [sym_pkg::SYM_W-1:0]     data;        // decoded bytes, low byte first
    logic [sym_pkg::SYM_BYTES-1:0] charisk;     // K-character per byte
    logic [sym_pkg::SYM_BYTES-1:0] disperr;     // running disparity error per byte
    logic [sym_pkg::SYM_BYTES-1:0] notintable;  // code not in 8b/10b table

    // decoder side, new word every cycle
    modport source (
        output data,
        output charisk,
        output disperr,
        output notintable
    );

    // consumer side
    modport sink (
        input data,
        input charisk,
        input disperr,
        input notintable
    );

endinterface

// ==== source/sym_pkg.sv ====
// decoded 8b/10b symbol widths, byte count and K28.5 comma code

package sym_pkg;

    // --------------------
    // symbol word layout
    // --------------------
    localparam int BYTE_W    = 8;               // one decoded byte
    localparam int SYM_BYTES = 2;               // bytes per rx word
    localparam int SYM_W     = SYM_BYTES * BYTE_W;  // rx data width

    // byte 0 is the low byte, byte 1 the high byte
    // K-flag, disparity and not-in-table flags are one bit per byte

    // --------------------
    // control characters
    // --------------------
    // K28.5 comma, only counted in the low byte
    // high byte may carry other K codes of the data protocol
    localparam logic [BYTE_W-1:0] COMMA_K28_5 = 8'hBC;

endpackage

// ==== test/evr_link_rx_props.sv ====
// concurrent assertions on the link controller outputs bound into link_reset_fsm

`timescale 1ns/1ps

module evr_link_rx_props (
    input logic                                  clk,
    input logic                                  rst,
    input link_ctrl_pkg::link_state_t            state,
    input logic                                  ready,
    input logic                                  gt_reset,
    input logic                                  soft_reset,
    input logic                                  reset_pulse,
    input logic [link_ctrl_pkg::RESET_CNT_W-1:0] reset_cnt
);

    int fail_cnt = 0;   // failed assertion count

    // internal reset strobe is a single cycle
    pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
        (gt_reset && !soft_reset) |=> !(gt_reset && !soft_reset))
        else begin
            fail_cnt++;
            $error("gt_reset high on two cycles without soft_reset");
        end

    // ready only follows a cycle spent in READY
    ready_from_state: assert property (@(posedge clk) disable iff (rst)
        $rose(ready) |-> ($past(state) == link_ctrl_pkg::READY))
        else begin
            fail_cnt++;
            $error("ready rose while the FSM was not in READY");
        end

    // counter steps by one right after a pulse
    cnt_step: assert property (@(posedge clk) disable iff (rst)
        (reset_cnt != $past(reset_cnt)) |->
            ($past(reset_pulse) && (reset_cnt == $past(reset_cnt) + 1'b1)))
        else begin
            fail_cnt++;
            $error("reset_cnt changed without a pulse or by more than one");
        end

endmodule

bind link_reset_fsm evr_link_rx_props props_i (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .ready       (ready),
    .gt_reset    (gt_reset),
    .soft_reset  (soft_reset),
    .reset_pulse (reset_pulse),
    .reset_cnt   (reset_cnt)
);

// ==== test/evr_link_rx_tb.sv ====
// rx link supervisor testbench with clock, transceiver model, stimulus, data checker and timeout

`timescale 1ns/1ps

module evr_link_rx_tb;

    localparam int COMMAS_NEEDED = 8;
    localparam int CHECK_TIMEOUT = 40;
    localparam int RESET_HOLD    = 32;      // reset_done low after each gt_reset
    localparam int MAX_CYCLES    = 2000;    // whole sequence runs about 140 cycles

    logic                                  clk;
    logic                                  rst;
    logic [sym_pkg::SYM_W-1:0]             rxdata;
    logic [sym_pkg::SYM_BYTES-1:0]         rxcharisk;
    logic [sym_pkg::SYM_BYTES-1:0]         rxdisperr;
    logic [sym_pkg::SYM_BYTES-1:0]         rxnotintable;
    logic                                  reset_done = 1'b1;  // transceiver up at start
    logic                                  soft_reset;
    logic [sym_pkg::SYM_W-1:0]             rxdata_out;
    logic [sym_pkg::SYM_BYTES-1:0]         rxcharisk_out;
    logic                                  ready;
    logic                                  gt_reset;
    logic [link_ctrl_pkg::RESET_CNT_W-1:0] reset_cnt;

    logic [31:0]                           rand_state = 32'hf7a6f160;
    int                                    down_left  = 0;     // model cycles left in reset
    int                                    cycle_cnt  = 0;
    logic                                  ready_q    = 1'b0;  // ready before the last edge
    int                                    n;
    logic [link_ctrl_pkg::RESET_CNT_W-1:0] cnt_before;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    evr_link_rx #(
        .COMMAS_NEEDED (COMMAS_NEEDED),
        .CHECK_TIMEOUT (CHECK_TIMEOUT)
    ) evr_link_rx_i (
        .clk (clk), .rst (rst), .rxdata (rxdata), .rxcharisk (rxcharisk),
        .rxdisperr (rxdisperr), .rxnotintable (rxnotintable), .reset_done (reset_done),
        .soft_reset (soft_reset), .rxdata_out (rxdata_out), .rxcharisk_out (rxcharisk_out),
        .ready (ready), .gt_reset (gt_reset), .reset_cnt (reset_cnt)
    );

    // --------------------
    // helpers
    // --------------------
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // data passes only if the link was aligned at the sampling edge
    function automatic logic [15:0] expected_rxdata(input logic ready_prev,
                                                    input logic [15:0] data_prev);
        return ready_prev ? data_prev : 16'h0000;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // drive at a falling edge and hold for one cycle
    task automatic send_word(input logic [15:0] data, input logic [1:0] k,
                             input logic [1:0] derr, input logic [1:0] nit);
        rxdata       = data;
        rxcharisk    = k;
        rxdisperr    = derr;
        rxnotintable = nit;
        @(negedge clk);
    endtask

    task automatic send_comma();
        rand_state = lcg_next(rand_state);
        send_word({rand_state[31:24], sym_pkg::COMMA_K28_5}, {rand_state[20], 1'b1}, 0, 0);
    endtask

    task automatic send_high_comma();   // K28.5 in the high byte only
        rand_state = lcg_next(rand_state);
        send_word({sym_pkg::COMMA_K28_5, rand_state[31:24]}, 2'b10, 0, 0);
    endtask

    task automatic send_idle();
        rand_state = lcg_next(rand_state);
        send_word(rand_state[31:16], rand_state[13:12], 0, 0);
    endtask

    task automatic commas_until_ready(input int limit, input string name);
        int sent;
        sent = 0;
        while (!ready && sent < limit) begin
            send_comma();
            sent++;
        end
        check(name, 32'd1, 32'(ready));
    endtask

    // after the error word ready drops in cycle 3
    // gt_reset pulses in cycle 4 and reset_cnt steps in cycle 5
    task automatic inject_error(input logic [1:0] derr, input logic [1:0] nit);
        logic [link_ctrl_pkg::RESET_CNT_W-1:0] cnt0;
        cnt0       = reset_cnt;
        rand_state = lcg_next(rand_state);
        send_word(rand_state[31:16], 2'b00, derr, nit);
        for (int i = 1; i <= 5; i++) begin
            check("gt_reset after error", 32'(i == 4), 32'(gt_reset));
            check("ready after error", 32'(i < 3), 32'(ready));
            check("reset_cnt after error", (i == 5) ? cnt0 + 1 : cnt0, reset_cnt);
            if (i >= 4) check("rxdata_out gated", 32'd0, 32'(rxdata_out));
            send_idle();
        end
    endtask

    // --------------------
    // transceiver model, data checker, timeout
    // --------------------
    always @(posedge clk) begin
        #2;
        if (gt_reset === 1'b1) down_left = RESET_HOLD;
        else if (down_left != 0) down_left = down_left - 1;
    end

    always @(negedge clk) reset_done <= (down_left == 0);

    always @(posedge clk) begin
        #2;     // outputs settled and inputs still held
        if (!rst) begin
            check("rxdata_out", 32'(expected_rxdata(ready_q, rxdata)), 32'(rxdata_out));
            check("rxcharisk_out", 32'(rxcharisk), 32'(rxcharisk_out));
        end
        ready_q = ready;
    end

    // bound controller assertions count their failures
    always @(posedge clk) begin
        #1;
        if (evr_link_rx_i.link_reset_fsm_i.props_i.fail_cnt != 0) begin
            $display("a controller assertion failed, see the error above");
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: test sequence did not end within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "run aborted");
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        rst          = 1'b1;
        rxdata       = '0;
        rxcharisk    = '0;
        rxdisperr    = '0;
        rxnotintable = '0;
        soft_reset   = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check("ready after reset", 32'd0, 32'(ready));
        check("gt_reset after reset", 32'd0, 32'(gt_reset));
        check("rxdata_out after reset", 32'd0, 32'(rxdata_out));
        check("reset_cnt after reset", 32'd0, reset_cnt);

        commas_until_ready(COMMAS_NEEDED + 3, "ready after commas");
        repeat (12) begin
            send_idle();
            send_comma();
        end

        // disparity error and recovery once reset_done is back
        inject_error(2'b01, 2'b00);
        commas_until_ready(RESET_HOLD + COMMAS_NEEDED + 3, "ready after recovery");
        repeat (5) send_idle();

        // not-in-table error followed by high byte commas until the timeout reset
        inject_error(2'b00, 2'b10);
        cnt_before = reset_cnt;
        n          = 0;
        while (gt_reset !== 1'b1 && n < CHECK_TIMEOUT + 5) begin
            check("ready with high byte commas", 32'd0, 32'(ready));
            send_high_comma();
            n++;
        end
        check("gt_reset on timeout", 32'd1, 32'(gt_reset));
        send_high_comma();
        check("reset_cnt after timeout", cnt_before + 1, reset_cnt);

        // soft reset reaches gt_reset directly and is not counted
        cnt_before = reset_cnt;
        soft_reset = 1'b1;
        #1;
        check("gt_reset with soft_reset", 32'd1, 32'(gt_reset));
        @(negedge clk);
        soft_reset = 1'b0;
        #1;
        check("gt_reset after soft_reset", 32'd0, 32'(gt_reset));
        @(negedge clk);
        repeat (3) send_idle();
        check("reset_cnt after soft_reset", cnt_before, reset_cnt);

        repeat (4) send_idle();
        $display("Verification passed");
        $finish;
    end

endmodule
